//--- src/vec_settings.svh
/*
 * sizing of the vector unit: register file geometry and port counts
 * included by the lane package and by every RTL module that needs a width
 */
`ifndef VEC_SETTINGS_SVH
`define VEC_SETTINGS_SVH

// width of one vector register in bits
`define VEC_VREG_W 128

// bytes per register, one byte enable each
`define VEC_VREG_B (`VEC_VREG_W / 8)

// architectural register count
`define VEC_NREGS 32

// register address width follows from the count
`define VEC_ADDR_W $clog2(`VEC_NREGS)

// read ports: alu vs2, alu vs1, store path
`define VEC_PORTS_RD 3

// write ports: alu result, external load
`define VEC_PORTS_WR 2

`endif

//--- src/vec_isa_pkg.sv
/*
 * instruction word of the vector ALU, its two views and the field encodings
 * the format bit picks the view, register fields are always 5 bits
 */
package vec_isa_pkg;

    // element width, code 3 is reserved
    typedef enum logic [1:0] {
        SEW_8   = 2'd0,
        SEW_16  = 2'd1,
        SEW_32  = 2'd2,
        SEW_ILL = 2'd3
    } sew_e;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4
    } alu_op_e;

    // second operand comes from vs1 or from the immediate
    typedef enum logic {
        FMT_VV = 1'b0,
        FMT_VI = 1'b1
    } fmt_e;

    // vd = vs2 op vs1
    typedef struct packed {
        alu_op_e     op;
        fmt_e        fmt;
        sew_e        sew;
        logic [4:0]  vl;
        logic [4:0]  vs2;
        logic [4:0]  vs1;
        logic [4:0]  vd;
        logic [5:0]  rsvd;
    } instr_vv_t;

    // vd = vs2 op sext(imm), imm sits where vs1 would be
    typedef struct packed {
        alu_op_e            op;
        fmt_e               fmt;
        sew_e               sew;
        logic [4:0]         vl;
        logic [4:0]         vs2;
        logic signed [4:0]  imm;
        logic [4:0]         vd;
        logic [5:0]         rsvd;
    } instr_vi_t;

    typedef union packed {
        instr_vv_t vv;
        instr_vi_t vi;
    } instr_u;

endpackage

//--- src/vec_lane_pkg.sv
/*
 * bundles moving between the ALU, the load and store paths and the register file
 * widths come from the settings header
 */
`include "vec_settings.svh"

package vec_lane_pkg;

    // one register-file write port
    // be gates single bytes, we gates the whole port
    typedef struct packed {
        logic                    we;
        logic [`VEC_ADDR_W-1:0]  addr;
        logic [`VEC_VREG_B-1:0]  be;
        logic [`VEC_VREG_W-1:0]  data;
    } rf_wr_t;

    // an external load is a write port driven from outside
    typedef rf_wr_t ld_req_t;

    // store request, data returns one cycle later
    typedef struct packed {
        logic                    valid;
        logic [`VEC_ADDR_W-1:0]  addr;
    } st_req_t;

endpackage

//--- src/vec_regfile.sv
/*
 * XOR-based multi-ported vector register file built from 1W banks
 * writes land at the clock edge, reads are combinational
 */
`timescale 1ns/1ps
`include "vec_settings.svh"

module vec_regfile (
    input  logic                                       clk_i,
    input  vec_lane_pkg::rf_wr_t [`VEC_PORTS_WR-1:0]   wr_i,
    input  logic [`VEC_PORTS_RD-1:0][`VEC_ADDR_W-1:0]  rd_addr_i,
    output logic [`VEC_PORTS_RD-1:0][`VEC_VREG_W-1:0]  rd_data_o
);

    localparam int NRD    = `VEC_PORTS_RD;
    localparam int NWR    = `VEC_PORTS_WR;
    localparam int NBYTES = `VEC_VREG_B;
    // external read columns, then one loopback column per other write port
    localparam int NCOL   = NRD + NWR - 1;

    // address and data seen by each bank, indexed [column][row]
    logic [NCOL-1:0][NWR-1:0][`VEC_ADDR_W-1:0] col_addr;
    logic [NCOL-1:0][NWR-1:0][`VEC_VREG_W-1:0] col_data;

    // column address map
    always_comb begin
        // external ports read the same address in every row
        for (int c = 0; c < NRD; c++) begin
            for (int r = 0; r < NWR; r++) begin
                col_addr[c][r] = rd_addr_i[c];
            end
        end
        // loopback column k of row r tracks write port k,
        // shifted by one past the row's own port since a row never reads itself
        for (int k = 0; k < NWR - 1; k++) begin
            for (int r = 0; r < NWR; r++) begin
                if (k < r) begin
                    col_addr[NRD + k][r] = wr_i[k].addr;
                end else begin
                    col_addr[NRD + k][r] = wr_i[k + 1].addr;
                end
            end
        end
    end

    // one row of banks per write port
    for (genvar gw = 0; gw < NWR; gw++) begin : g_row

        logic [`VEC_VREG_W-1:0] wr_data;

        // stored value is new data xor what the other rows hold at this address,
        // so the xor over all rows gives back the new data
        always_comb begin
            int col;
            wr_data = wr_i[gw].data;
            for (int r = 0; r < NWR; r++) begin
                if (r != gw) begin
                    // loopback column in row r that follows this write port
                    col = (gw < r) ? NRD + gw : NRD + gw - 1;
                    wr_data = wr_data ^ col_data[col][r];
                end
            end
        end

        // every column of the row holds the same contents
        for (genvar gc = 0; gc < NCOL; gc++) begin : g_col

            logic [`VEC_VREG_W-1:0] bank [`VEC_NREGS];

            always_ff @(posedge clk_i) begin
                if (wr_i[gw].we) begin
                    for (int b = 0; b < NBYTES; b++) begin
                        if (wr_i[gw].be[b]) begin
                            bank[wr_i[gw].addr][b*8 +: 8] <= wr_data[b*8 +: 8];
                        end
                    end
                end
            end

            assign col_data[gc][gw] = bank[col_addr[gc][gw]];

        end
    end

    // read result is the xor of the port's column across all rows
    always_comb begin
        for (int p = 0; p < NRD; p++) begin
            rd_data_o[p] = '0;
            for (int r = 0; r < NWR; r++) begin
                rd_data_o[p] = rd_data_o[p] ^ col_data[p][r];
            end
        end
    end

    // ALU result and external load must never target the same register together,
    // the loopback reads would then see a half-written register
    for (genvar ga = 0; ga < NWR; ga++) begin : g_chk_a
        for (genvar gb = ga + 1; gb < NWR; gb++) begin : g_chk_b
            a_wr_no_collision: assert property (@(posedge clk_i)
                !(wr_i[ga].we && wr_i[gb].we && (wr_i[ga].addr == wr_i[gb].addr)))
                else $error("vec_regfile: write ports %0d and %0d hit v%0d",
                            ga, gb, wr_i[ga].addr);
        end
    end

endmodule

//--- src/vec_alu.sv
/*
 * element-wise vector ALU: decode, compute on 8/16/32-bit elements, build byte
 * enables from sew and vl, result leaves through a registered write port
 */
`timescale 1ns/1ps
`include "vec_settings.svh"

module vec_alu (
    input  logic                            clk_i,
    input  logic                            reset_i,
    input  logic                            instr_valid_i,
    input  vec_isa_pkg::instr_u             instr_i,
    output logic [1:0][`VEC_ADDR_W-1:0]     rs_addr_o,
    input  logic [1:0][`VEC_VREG_W-1:0]     rs_data_i,
    output vec_lane_pkg::rf_wr_t            wr_o
);

    localparam int NBYTES = `VEC_VREG_B;

    vec_isa_pkg::instr_vv_t  vv;
    vec_isa_pkg::instr_vi_t  vi;
    logic [31:0]             imm_ext;
    logic [`VEC_VREG_W-1:0]  opa;
    logic [`VEC_VREG_W-1:0]  opb;
    logic [`VEC_VREG_W-1:0]  res8;
    logic [`VEC_VREG_W-1:0]  res16;
    logic [`VEC_VREG_W-1:0]  res32;
    logic [`VEC_VREG_W-1:0]  res;
    logic [4:0]              vl_max;
    logic [4:0]              vl_eff;
    logic [5:0]              nbytes;
    logic [NBYTES-1:0]       be;
    vec_lane_pkg::rf_wr_t    wr_q;

    // one element, narrow elements are zero-extended and the low bits kept
    function automatic logic [31:0] elem_calc(vec_isa_pkg::alu_op_e op,
                                              logic [31:0] a, logic [31:0] b);
        case (op)
            vec_isa_pkg::ALU_ADD: return a + b;
            vec_isa_pkg::ALU_SUB: return a - b;
            vec_isa_pkg::ALU_AND: return a & b;
            vec_isa_pkg::ALU_OR:  return a | b;
            vec_isa_pkg::ALU_XOR: return a ^ b;
            default:              return '0;
        endcase
    endfunction

    // both views of the same word
    assign vv = instr_i.vv;
    assign vi = instr_i.vi;

    // operand fetch, vs1 address is harmless in the immediate form
    assign rs_addr_o[0] = vv.vs2;
    assign rs_addr_o[1] = vv.vs1;

    assign opa     = rs_data_i[0];
    assign imm_ext = {{27{vi.imm[4]}}, vi.imm};

    // immediate is sign-extended to sew, then copied into every element
    always_comb begin
        opb = rs_data_i[1];
        if (vv.fmt == vec_isa_pkg::FMT_VI) begin
            case (vv.sew)
                vec_isa_pkg::SEW_8:  opb = {NBYTES{imm_ext[7:0]}};
                vec_isa_pkg::SEW_16: opb = {(NBYTES/2){imm_ext[15:0]}};
                default:             opb = {(NBYTES/4){imm_ext}};
            endcase
        end
    end

    // one result per element width, carries stop at the element boundary
    always_comb begin
        logic [31:0] t;
        for (int e = 0; e < NBYTES; e++) begin
            t = elem_calc(vv.op, 32'(opa[e*8 +: 8]), 32'(opb[e*8 +: 8]));
            res8[e*8 +: 8] = t[7:0];
        end
        for (int e = 0; e < NBYTES/2; e++) begin
            t = elem_calc(vv.op, 32'(opa[e*16 +: 16]), 32'(opb[e*16 +: 16]));
            res16[e*16 +: 16] = t[15:0];
        end
        for (int e = 0; e < NBYTES/4; e++) begin
            res32[e*32 +: 32] = elem_calc(vv.op, opa[e*32 +: 32], opb[e*32 +: 32]);
        end
    end

    // element count per register for this sew; illegal sew writes nothing
    always_comb begin
        res    = res32;
        vl_max = 5'(NBYTES/4);
        case (vv.sew)
            vec_isa_pkg::SEW_8: begin
                res    = res8;
                vl_max = 5'(NBYTES);
            end
            vec_isa_pkg::SEW_16: begin
                res    = res16;
                vl_max = 5'(NBYTES/2);
            end
            vec_isa_pkg::SEW_32: ;
            default: vl_max = '0;
        endcase
    end

    // clamp vl, then enable the leading vl_eff elements byte by byte
    assign vl_eff = (vv.vl > vl_max) ? vl_max : vv.vl;
    assign nbytes = {1'b0, vl_eff} << vv.sew;

    always_comb begin
        for (int b = 0; b < NBYTES; b++) begin
            be[b] = (b < int'(nbytes));
        end
    end

    // result register, write port active one cycle after issue
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            wr_q.we <= 1'b0;
        end else begin
            wr_q.we <= instr_valid_i;
        end
        if (instr_valid_i) begin
            wr_q.addr <= vv.vd;
            wr_q.be   <= be;
            wr_q.data <= res;
        end
    end

    assign wr_o = wr_q;

    // issuing side must never send the reserved element width
    a_sew_legal: assert property (@(posedge clk_i) disable iff (reset_i)
        instr_valid_i |-> (vv.sew != vec_isa_pkg::SEW_ILL))
        else $error("vec_alu: valid instruction with illegal sew");

endmodule

//--- src/vec_unit.sv
/*
 * vector unit top: ALU on write port 0, external load on write port 1,
 * store path on read port 2 with a registered output stage
 */
`timescale 1ns/1ps
`include "vec_settings.svh"

module vec_unit (
    input  logic                    clk_i,
    input  logic                    reset_i,
    input  logic                    instr_valid_i,
    input  vec_isa_pkg::instr_u     instr_i,
    input  vec_lane_pkg::ld_req_t   ld_i,
    input  vec_lane_pkg::st_req_t   st_i,
    output logic                    st_valid_o,
    output logic [`VEC_VREG_W-1:0]  st_data_o
);

    // port assignment on the register file
    localparam int WP_ALU = 0;
    localparam int WP_LD  = 1;
    localparam int RP_ST  = 2;

    vec_lane_pkg::rf_wr_t [`VEC_PORTS_WR-1:0]   rf_wr;
    vec_lane_pkg::rf_wr_t                       alu_wr;
    logic [1:0][`VEC_ADDR_W-1:0]                alu_rs_addr;
    logic [`VEC_PORTS_RD-1:0][`VEC_ADDR_W-1:0]  rd_addr;
    logic [`VEC_PORTS_RD-1:0][`VEC_VREG_W-1:0]  rd_data;
    logic                                       st_valid_q;
    logic [`VEC_VREG_W-1:0]                     st_data_q;

    vec_alu i_vec_alu (
        .clk_i         ( clk_i          ),
        .reset_i       ( reset_i        ),
        .instr_valid_i ( instr_valid_i  ),
        .instr_i       ( instr_i        ),
        .rs_addr_o     ( alu_rs_addr    ),
        .rs_data_i     ( rd_data[1:0]   ),
        .wr_o          ( alu_wr         )
    );

    // ALU operands on read ports 0 and 1, store on port 2
    assign rd_addr[1:0]  = alu_rs_addr;
    assign rd_addr[RP_ST] = st_i.addr;

    // load bypasses the ALU and goes straight to its own write port
    assign rf_wr[WP_ALU] = alu_wr;
    assign rf_wr[WP_LD]  = ld_i;

    vec_regfile i_vec_regfile (
        .clk_i     ( clk_i   ),
        .wr_i      ( rf_wr   ),
        .rd_addr_i ( rd_addr ),
        .rd_data_o ( rd_data )
    );

    // store data captured in the request cycle, valid one cycle later
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            st_valid_q <= 1'b0;
        end else begin
            st_valid_q <= st_i.valid;
        end
        if (st_i.valid) begin
            st_data_q <= rd_data[RP_ST];
        end
    end

    assign st_valid_o = st_valid_q;
    assign st_data_o  = st_data_q;

endmodule

//--- bench/vec_unit_checker.sv
/*
 * store scoreboard: expected words queue up in request order and each
 * store response is compared mid-cycle, with a limit on how long one may take
 */
`timescale 1ns/1ps
`include "vec_settings.svh"

module vec_unit_checker (
    input  logic                    clk_i,
    input  logic                    reset_i,
    input  logic                    exp_valid_i,
    input  logic [`VEC_VREG_W-1:0]  exp_data_i,
    input  logic                    st_valid_i,
    input  logic [`VEC_VREG_W-1:0]  st_data_i,
    output int                      checks_o,
    output int                      errors_o,
    output int                      pending_o
);

    // cycles a request may wait for its response
    localparam int max_wait = 16;

    logic [`VEC_VREG_W-1:0] exp_q [$];
    logic [`VEC_VREG_W-1:0] exp_word;
    int                     wait_cnt;

    initial begin
        checks_o  = 0;
        errors_o  = 0;
        pending_o = 0;
        wait_cnt  = 0;
        forever begin
            // registered outputs and bench strobes are both settled here
            @(negedge clk_i);
            if (!reset_i) begin
                if (st_valid_i) begin
                    if (exp_q.size() == 0) begin
                        $display("store response at %0t without a pending request", $time);
                        errors_o++;
                    end else begin
                        exp_word = exp_q.pop_front();
                        checks_o++;
                        if (st_data_i !== exp_word) begin
                            $display("ERR t=%0t st_data_o exp=%h got=%h",
                                     $time, exp_word, st_data_i);
                            errors_o++;
                        end
                    end
                    wait_cnt = 0;
                end else if (exp_q.size() != 0) begin
                    wait_cnt++;
                    if (wait_cnt > max_wait) begin
                        $display("no store response within %0d cycles at %0t", max_wait, $time);
                        errors_o++;
                        void'(exp_q.pop_front());
                        wait_cnt = 0;
                    end
                end
                // a request seen now is answered one cycle later
                if (exp_valid_i) begin
                    exp_q.push_back(exp_data_i);
                end
            end
            pending_o = exp_q.size();
        end
    end

endmodule

//--- bench/vec_unit_tb.sv
/*
 * testbench of the vector unit: replays the pattern file against the DUT,
 * the checker compares each store response with the expected word
 */
`timescale 1ns/1ps
`include "vec_settings.svh"

module vec_unit_tb;

    // cycles allowed for outstanding stores at the end of a test
    localparam int drain_limit = 64;

    logic                    clk;
    logic                    reset;
    logic                    instr_valid;
    vec_isa_pkg::instr_u     instr;
    vec_lane_pkg::ld_req_t   ld;
    vec_lane_pkg::st_req_t   st;
    logic                    st_valid;
    logic [`VEC_VREG_W-1:0]  st_data;
    logic                    exp_valid;
    logic [`VEC_VREG_W-1:0]  exp_data;
    int                      checks;
    int                      errors;
    int                      pending;
    int                      checks_seen;
    int                      errors_seen;
    int                      tests_run;
    int                      tests_failed;
    bit                      aborted;

    vec_unit i_vec_unit (
        .clk_i         ( clk         ),
        .reset_i       ( reset       ),
        .instr_valid_i ( instr_valid ),
        .instr_i       ( instr       ),
        .ld_i          ( ld          ),
        .st_i          ( st          ),
        .st_valid_o    ( st_valid    ),
        .st_data_o     ( st_data     )
    );

    vec_unit_checker i_vec_unit_checker (
        .clk_i       ( clk       ),
        .reset_i     ( reset     ),
        .exp_valid_i ( exp_valid ),
        .exp_data_i  ( exp_data  ),
        .st_valid_i  ( st_valid  ),
        .st_data_i   ( st_data   ),
        .checks_o    ( checks    ),
        .errors_o    ( errors    ),
        .pending_o   ( pending   )
    );

    // 8 ns period
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // inputs change 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic drop_strobes();
        instr_valid = 1'b0;
        ld.we       = 1'b0;
        st.valid    = 1'b0;
        exp_valid   = 1'b0;
    endtask

    // blank-separated word of a pattern line
    function automatic string word_at(string line, int start);
        int stop;
        stop = start;
        while (stop < line.len() && line[stop] != " " && line[stop] != "\n"
               && line[stop] != "\r") begin
            stop++;
        end
        if (stop == start) begin
            return "";
        end
        return line.substr(start, stop - 1);
    endfunction

    // wait for the checker to empty its queue, then report the test
    task automatic finish_test(string name);
        int waited;
        waited = 0;
        while (pending != 0 && waited < drain_limit) begin
            next_cycle();
            waited++;
        end
        tests_run++;
        if (pending != 0) begin
            $display("test %s: store responses missing after %0d cycles", name, drain_limit);
            tests_failed++;
            aborted = 1'b1;
        end else if (errors != errors_seen) begin
            $display("test %s: failed, %0d errors", name, errors - errors_seen);
            tests_failed++;
        end else begin
            $display("test %s: passed, %0d checks", name, checks - checks_seen);
        end
        errors_seen = errors;
        checks_seen = checks;
    endtask

    initial begin
        int                      fd;
        int                      n;
        int                      want;
        int                      num;
        string                   line;
        string                   cmd;
        logic [15:0]             be;
        logic [31:0]             iword;
        logic [`VEC_VREG_W-1:0]  word;

        reset        = 1'b1;
        instr_valid  = 1'b0;
        instr        = '0;
        ld           = '0;
        st           = '0;
        exp_valid    = 1'b0;
        exp_data     = '0;
        checks_seen  = 0;
        errors_seen  = 0;
        tests_run    = 0;
        tests_failed = 0;
        aborted      = 1'b0;
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;

        fd = $fopen("bench/vec_unit_patterns.txt", "r");
        if (fd == 0) begin
            $display("pattern file bench/vec_unit_patterns.txt could not be opened");
            aborted = 1'b1;
        end
        while (fd != 0 && !aborted && !$feof(fd)) begin
            line = "";
            want = 0;
            n    = $fgets(line, fd);
            cmd  = word_at(line, 0);
            if (cmd == "load") begin
                want     = 3;
                n        = $sscanf(line, "load %d %h %h", num, be, word);
                ld.we    = 1'b1;
                ld.addr  = num[4:0];
                ld.be    = be;
                ld.data  = word;
                next_cycle();
                drop_strobes();
            end else if (cmd == "instr") begin
                want        = 1;
                n           = $sscanf(line, "instr %h", iword);
                instr       = iword;
                instr_valid = 1'b1;
                next_cycle();
                drop_strobes();
            end else if (cmd == "store") begin
                // request and expected word travel together
                want      = 2;
                n         = $sscanf(line, "store %d %h", num, word);
                st.valid  = 1'b1;
                st.addr   = num[4:0];
                exp_valid = 1'b1;
                exp_data  = word;
                next_cycle();
                drop_strobes();
            end else if (cmd == "idle") begin
                want = 1;
                n    = $sscanf(line, "idle %d", num);
                repeat (num) next_cycle();
            end else if (cmd == "end") begin
                finish_test(word_at(line, 4));
            end else if (cmd.len() > 0 && cmd.substr(0, 0) != "#") begin
                $display("unknown command in pattern file: %s", cmd);
                aborted = 1'b1;
            end
            // fewer fields than the command needs
            if (want != 0 && n != want) begin
                $display("pattern line for %s could not be parsed", cmd);
                aborted = 1'b1;
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end

        $display("tests: %0d run, %0d failed; checks: %0d, errors: %0d",
                 tests_run, tests_failed, checks, errors);
        if (!aborted && tests_run > 0 && tests_failed == 0 && errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

//--- bench/vec_unit_patterns.txt
# load <reg> <byte enables> <data> | instr <word> | store <reg> <expected data>
# idle <cycles> | end <test name>; reg and cycles are decimal, everything else hex
load 1 ffff 000102030405060708090a0b0c0d0e0f
store 1 000102030405060708090a0b0c0d0e0f
load 1 00ff ffffffffffffffffffffffffffffffff
store 1 0001020304050607ffffffffffffffff
end load_store
load 2 ffff 11111111222222223333333344444444
load 3 ffff 0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f
load 4 ffff aaaaaaaaaaaaaaaaaaaaaaaaaaaaaaaa
instr 88821900
load 5 ffff 55555555555555555555555555555555
store 4 1e1e1e1e2d2d2d2d3c3c3c3c4b4b4b4b
store 5 55555555555555555555555555555555
end port_mix
load 6 ffff 7fff80007fff80007fff80007fff8000
load 7 ffff 80018001800180018001800180018001
instr 03e63a00
instr 07e63a40
instr 0be63a80
instr 23e63ac0
instr 27e63b00
instr 2be63b40
instr 43e63b80
instr 47e63bc0
instr 4be63c00
instr 63e63c40
instr 67e63c80
instr 6be63cc0
instr 83e63d00
instr 87e63d40
instr 8be63d80
idle 1
store 8 ff000001ff000001ff000001ff000001
store 9 00000001000000010000000100000001
store 10 00010001000100010001000100010001
store 11 fffe00fffffe00fffffe00fffffe00ff
store 12 fffefffffffefffffffefffffffeffff
store 13 fffdfffffffdfffffffdfffffffdffff
store 14 00018000000180000001800000018000
store 15 00018000000180000001800000018000
store 16 00018000000180000001800000018000
store 17 ffff8001ffff8001ffff8001ffff8001
store 18 ffff8001ffff8001ffff8001ffff8001
store 19 ffff8001ffff8001ffff8001ffff8001
store 20 fffe0001fffe0001fffe0001fffe0001
store 21 fffe0001fffe0001fffe0001fffe0001
store 22 fffe0001fffe0001fffe0001fffe0001
end vv_ops
instr 13e6edc0
instr 17e6ee00
instr 1be6ee40
idle 1
store 23 7cfc7dfd7cfc7dfd7cfc7dfd7cfc7dfd
store 24 7ffc7ffd7ffc7ffd7ffc7ffd7ffc7ffd
store 25 7fff7ffd7fff7ffd7fff7ffd7fff7ffd
end vi_imm
load 26 ffff 55555555555555555555555555555555
load 27 ffff 3c3c3c3c3c3c3c3c3c3c3c3c3c3c3c3c
instr 04663e80
instr 80063ec0
idle 1
store 26 55555555555555555555000100000001
store 27 3c3c3c3c3c3c3c3c3c3c3c3c3c3c3c3c
end vl_limits
instr 08863f00
idle 1
instr 889c3f40
idle 1
store 29 80008000800080008000800080008000
end chain

//--- build.f
+incdir+src
src/vec_isa_pkg.sv
src/vec_lane_pkg.sv
src/vec_regfile.sv
src/vec_alu.sv
src/vec_unit.sv
bench/vec_unit_checker.sv
bench/vec_unit_tb.sv

//--- Makefile
# Verilator flow for the vector unit, every variable can be set on the command line
VERILATOR ?= verilator
TB_TOP    ?= vec_unit_tb
RTL_TOP   ?= vec_unit
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= Everything OK

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o $(TB_TOP)

# the log decides pass or fail
run: build
	./$(BUILD_DIR)/$(TB_TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) --lint-only --timing --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
